//--- design/fetch_pkg.sv
package fetch_pkg;

  // ========================================
  // widths with a meaning on the fetch path
  // ========================================

  // byte address as seen by the fetch unit and the bus
  typedef logic [31:0] addr_t;

  // line number, address bits 31..4
  typedef logic [27:0] tag_t;

  // one cache line of four instruction words
  // word k sits in bits 32k+31 down to 32k
  typedef logic [127:0] line_t;

  // one instruction word
  typedef logic [31:0] inst_t;

  // read response code, zero is okay
  typedef logic [1:0] resp_t;

  // ========================================
  // bus read master states
  // ========================================

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } reader_state_e;

endpackage

//--- design/line_if.sv
`timescale 1ns/1ps

interface line_if
  import fetch_pkg::*;
#(
  parameter int DEPTH = 4
) ();

  localparam int LVL_W = $clog2(DEPTH) + 1;

  // write side, driven by the bus reader
  logic             push;
  line_t            push_line;
  logic             push_err;

  // queue status
  logic             full;
  logic             empty;
  logic [LVL_W-1:0] level;

  // head of the queue, or the pushed line while empty
  line_t            head_line;
  logic             head_err;
  logic             byp_valid;

  // read side, driven by the pc tracker
  logic             pop;
  logic             flush;

  modport writer (
    output push, push_line, push_err,
    input  full, level
  );

  modport reader (
    output pop, flush,
    input  empty, head_line, head_err, byp_valid
  );

  modport queue (
    input  push, push_line, push_err, pop, flush,
    output full, level, empty, head_line, head_err, byp_valid
  );

endinterface

//--- design/bus_reader.sv
`timescale 1ns/1ps

module bus_reader
  import fetch_pkg::*;
#(
  parameter int    DEPTH    = 4,
  parameter addr_t RESET_PC = 32'h8000_0000
) (
  input  logic   clk,
  input  logic   rst_n,
  // read address channel
  input  logic   ar_ready_i,
  output logic   ar_valid_o,
  output addr_t  ar_addr_o,
  // read data channel
  input  logic   r_valid_i,
  output logic   r_ready_o,
  input  line_t  r_data_i,
  input  resp_t  r_resp_i,
  // from the program counter side
  input  tag_t   tag_i,
  input  logic   flush_i,
  line_if.writer lq
);

  localparam int LVL_W = $clog2(DEPTH) + 1;

  reader_state_e    state_q;
  reader_state_e    state_d;
  addr_t            addr_q;
  logic             stale_q;
  logic [LVL_W-1:0] level;
  tag_t             next_tag;
  logic             start;
  logic             ar_done;
  logic             r_done;

  // ========================================
  // prefetch address
  // ========================================

  // line after the newest one held in the queue
  assign level    = lq.level;
  assign next_tag = tag_i + tag_t'(level);

  assign start   = (state_q == RD_IDLE) && !lq.full;
  assign ar_done = ar_valid_o && ar_ready_i;
  assign r_done  = r_valid_i && r_ready_o;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      addr_q <= {RESET_PC[31:4], 4'b0000};
    end else if (start) begin
      addr_q <= {next_tag, 4'b0000};
    end
  end

  // ========================================
  // read FSM
  // ========================================

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RD_IDLE: begin
        if (!lq.full) begin
          state_d = RD_ADDR;
        end
      end
      RD_ADDR: begin
        if (ar_done) begin
          state_d = RD_DATA;
        end
      end
      RD_DATA: begin
        if (r_done) begin
          state_d = RD_IDLE;
        end
      end
      default: begin
        state_d = RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= RD_IDLE;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // a jump while the address is being taken already makes it stale
      if (start) begin
        stale_q <= flush_i;
      end else if (flush_i && state_q != RD_IDLE) begin
        stale_q <= 1'b1;
      end
    end
  end

  // ========================================
  // bus and queue outputs
  // ========================================

  assign ar_valid_o = (state_q == RD_ADDR);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = (state_q == RD_DATA);

  // response taken in any case, only a live one is pushed
  assign lq.push      = r_done && !stale_q && !flush_i;
  assign lq.push_line = r_data_i;
  assign lq.push_err  = (r_resp_i != 2'b00);

endmodule

//--- design/line_queue.sv
`timescale 1ns/1ps

module line_queue
  import fetch_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  line_if.queue lq
);

  localparam int AW = $clog2(DEPTH);

  // storage, line data plus one error bit per entry
  line_t            mem_q [DEPTH];
  logic [DEPTH-1:0] err_q;

  // pointers carry one extra wrap bit
  logic [AW:0]   wr_ptr_q;
  logic [AW:0]   rd_ptr_q;
  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;
  logic          do_push;
  logic          do_pop;

  assign wr_idx = wr_ptr_q[AW-1:0];
  assign rd_idx = rd_ptr_q[AW-1:0];

  assign do_push = lq.push && !lq.full;
  assign do_pop  = lq.pop && !lq.empty;

  // ========================================
  // pointers
  // ========================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (lq.flush) begin
      // flush wins over a push in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // ========================================
  // entry storage
  // ========================================

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_idx] <= lq.push_line;
      err_q[wr_idx] <= lq.push_err;
    end
  end

  // ========================================
  // status and head
  // ========================================

  assign lq.empty = (wr_ptr_q == rd_ptr_q);
  assign lq.full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                    (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
  assign lq.level = wr_ptr_q - rd_ptr_q;

  // empty queue hands the incoming line straight through
  assign lq.byp_valid = lq.empty && lq.push;

  always_comb begin
    if (lq.empty) begin
      lq.head_line = lq.push_line;
      lq.head_err  = lq.push_err;
    end else begin
      lq.head_line = mem_q[rd_idx];
      lq.head_err  = err_q[rd_idx];
    end
  end

endmodule

//--- design/pc_tracker.sv
`timescale 1ns/1ps

module pc_tracker
  import fetch_pkg::*;
#(
  parameter addr_t RESET_PC = 32'h8000_0000
) (
  input  logic   clk,
  input  logic   rst_n,
  input  addr_t  pc_i,
  input  logic   jmp_flush_i,
  output tag_t   tag_o,
  output logic   inst_valid_o,
  output inst_t  inst_o,
  output logic   inst_err_o,
  line_if.reader lq
);

  tag_t  tag_q;
  tag_t  pc_tag;
  logic  line_hit;
  line_t head;

  assign pc_tag   = pc_i[31:4];
  assign line_hit = (pc_tag == tag_q);

  // ========================================
  // buffer tag
  // ========================================

  // the tag names the line at the head of the queue
  always_ff @(posedge clk) begin
    if (rst_n) begin
      tag_q <= RESET_PC[31:4];
    end else if (jmp_flush_i || !line_hit) begin
      tag_q <= pc_tag;
    end
  end

  assign tag_o = tag_q;

  // ========================================
  // queue control
  // ========================================

  // leaving the line retires the head, a jump drops everything
  assign lq.flush = jmp_flush_i;
  assign lq.pop   = !jmp_flush_i && !line_hit && !lq.empty;

  // ========================================
  // instruction select
  // ========================================

  assign head = lq.head_line;

  assign inst_valid_o = line_hit && (!lq.empty || lq.byp_valid);

  always_comb begin
    unique case (pc_i[3:2])
      2'd0: inst_o = head[31:0];
      2'd1: inst_o = head[63:32];
      2'd2: inst_o = head[95:64];
      2'd3: inst_o = head[127:96];
      default: inst_o = head[31:0];
    endcase
  end

  // error travels with the whole line
  assign inst_err_o = lq.head_err;

endmodule

//--- design/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer
  import fetch_pkg::*;
#(
  parameter int    DEPTH    = 4,
  parameter addr_t RESET_PC = 32'h8000_0000
) (
  input  logic  clk,
  input  logic  rst_n,
  // read address channel
  output logic  ar_valid_o,
  input  logic  ar_ready_i,
  output addr_t ar_addr_o,
  // read data channel
  input  logic  r_valid_i,
  output logic  r_ready_o,
  input  line_t r_data_i,
  input  resp_t r_resp_i,
  // fetch unit side
  input  addr_t pc_i,
  input  logic  jmp_flush_i,
  output logic  inst_valid_o,
  output inst_t inst_o,
  output logic  inst_err_o
);

  tag_t buf_tag;

  // ========================================
  // queue link between the blocks
  // ========================================

  line_if #(
    .DEPTH (DEPTH)
  ) u_lq ();

  // ========================================
  // bus side
  // ========================================

  bus_reader #(
    .DEPTH    (DEPTH),
    .RESET_PC (RESET_PC)
  ) u_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_ready_i (ar_ready_i),
    .ar_valid_o (ar_valid_o),
    .ar_addr_o  (ar_addr_o),
    .r_valid_i  (r_valid_i),
    .r_ready_o  (r_ready_o),
    .r_data_i   (r_data_i),
    .r_resp_i   (r_resp_i),
    .tag_i      (buf_tag),
    .flush_i    (u_lq.flush),
    .lq         (u_lq.writer)
  );

  // ========================================
  // program counter side
  // ========================================

  pc_tracker #(
    .RESET_PC (RESET_PC)
  ) u_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc_i),
    .jmp_flush_i  (jmp_flush_i),
    .tag_o        (buf_tag),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_err_o   (inst_err_o),
    .lq           (u_lq.reader)
  );

  // line storage
  line_queue #(
    .DEPTH (DEPTH)
  ) u_queue (
    .clk   (clk),
    .rst_n (rst_n),
    .lq    (u_lq.queue)
  );

endmodule

//--- verification/mem_model.sv
`timescale 1ns/1ps

module mem_model
  import fetch_pkg::*;
#(
  parameter addr_t  BAD_ADDR = 32'h8000_4010,
  parameter integer SEED     = 32'h8f64
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  addr_t ar_addr_i,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output line_t r_data_o,
  output resp_t r_resp_o,
  output int    read_count_o
);

  integer seed;
  int     wait_q;
  addr_t  addr_q;
  logic   data_phase;

  initial begin
    seed = SEED;
    ar_ready_o   <= 1'b0;
    r_valid_o    <= 1'b0;
    r_data_o     <= '0;
    r_resp_o     <= 2'd0;
    read_count_o <= 0;
  end

  // every word holds its own address inverted
  function automatic line_t line_at(input addr_t a);
    line_t l;
    for (int k = 0; k < 4; k++) begin
      l[32*k +: 32] = ~(a + 32'(4 * k));
    end
    return l;
  endfunction

  always @(posedge clk) begin
    if (rst_n) begin
      ar_ready_o   <= 1'b0;
      r_valid_o    <= 1'b0;
      r_data_o     <= '0;
      r_resp_o     <= 2'd0;
      data_phase   <= 1'b0;
      read_count_o <= 0;
      wait_q       <= 0;
    end else if (!data_phase) begin
      if (ar_valid_i && ar_ready_o) begin
        ar_ready_o   <= 1'b0;
        addr_q       <= ar_addr_i;
        read_count_o <= read_count_o + 1;
        data_phase   <= 1'b1;
        wait_q       <= $unsigned($random(seed)) % 4;
      end else if (ar_valid_i) begin
        if (wait_q == 0) begin
          ar_ready_o <= 1'b1;
        end else begin
          wait_q <= wait_q - 1;
        end
      end
    end else if (r_valid_o && r_ready_i) begin
      r_valid_o  <= 1'b0;
      data_phase <= 1'b0;
      wait_q     <= $unsigned($random(seed)) % 4;
    end else if (!r_valid_o) begin
      if (wait_q == 0) begin
        r_valid_o <= 1'b1;
        r_data_o  <= line_at(addr_q);
        // marked line answers with a slave error
        r_resp_o  <= (addr_q == BAD_ADDR) ? 2'd2 : 2'd0;
      end else begin
        wait_q <= wait_q - 1;
      end
    end
  end

endmodule

//--- verification/fetch_buffer_asserts.sv
`timescale 1ns/1ps

module fetch_buffer_asserts
  import fetch_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  ar_valid_i,
  input logic  ar_ready_i,
  input addr_t ar_addr_i,
  input logic  r_ready_i,
  input logic  push_i,
  input logic  full_i
);

  // address request held steady until taken
  a_ar_hold: assert property (@(posedge clk) disable iff (rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else $error("read address dropped or changed before ar_ready");

  // only one read in flight, never both phases at once
  a_one_phase: assert property (@(posedge clk) disable iff (rst_n)
    !(ar_valid_i && r_ready_i))
    else $error("ar_valid and r_ready high together");

  a_reset_idle: assert property (@(posedge clk) rst_n |=> !ar_valid_i && !r_ready_i)
    else $error("bus handshake active right after reset");

  // prefetch must stop before the queue overflows
  a_no_push_full: assert property (@(posedge clk) disable iff (rst_n)
    !(push_i && full_i))
    else $error("line pushed into a full queue");

endmodule

bind fetch_buffer fetch_buffer_asserts u_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .ar_addr_i  (ar_addr_o),
  .r_ready_i  (r_ready_o),
  .push_i     (u_lq.push),
  .full_i     (u_lq.full)
);

//--- verification/tb_fetch_buffer.sv
`timescale 1ns/1ps

module tb_fetch_buffer
  import fetch_pkg::*;
();

  localparam int    CLK_PERIOD = 20;
  localparam int    SEED       = 32'h8f64;
  localparam int    TBL_SIZE   = 22;
  localparam int    DEPTH      = 4;
  localparam addr_t RESET_PC   = 32'h8000_0000;
  localparam addr_t BAD_LINE   = 32'h8000_4010;

  typedef struct packed {
    addr_t pc;
    logic  flush;
    logic  err;
  } entry_t;

  logic   clk;
  logic   rst_n;
  logic   ar_valid_o;
  logic   ar_ready_i;
  addr_t  ar_addr_o;
  logic   r_valid_i;
  logic   r_ready_o;
  line_t  r_data_i;
  resp_t  r_resp_i;
  addr_t  pc_i;
  logic   jmp_flush_i;
  logic   inst_valid_o;
  inst_t  inst_o;
  logic   inst_err_o;
  int     read_count;
  entry_t table_q[$];
  logic   seq_check;
  addr_t  exp_addr;
  addr_t  resync_addr;

  fetch_buffer #(
    .DEPTH    (DEPTH),
    .RESET_PC (RESET_PC)
  ) uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .ar_addr_o    (ar_addr_o),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .pc_i         (pc_i),
    .jmp_flush_i  (jmp_flush_i),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_err_o   (inst_err_o)
  );

  mem_model #(
    .BAD_ADDR (BAD_LINE),
    .SEED     (SEED)
  ) u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_valid_i   (ar_valid_o),
    .ar_ready_o   (ar_ready_i),
    .ar_addr_i    (ar_addr_o),
    .r_valid_o    (r_valid_i),
    .r_ready_i    (r_ready_o),
    .r_data_o     (r_data_i),
    .r_resp_o     (r_resp_i),
    .read_count_o (read_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic add_entry(input addr_t pc, input logic flush, input logic err);
    table_q.push_back({pc, flush, err});
  endtask

  // ========================================
  // stimulus table
  // ========================================

  task automatic build_table();
    // three lines of straight code
    for (int i = 0; i < 12; i++) begin
      add_entry(RESET_PC + 32'(4 * i), 1'b0, 1'b0);
    end
    // far jump, then walk into the bad line
    add_entry(32'h8000_4000, 1'b1, 1'b0);
    add_entry(32'h8000_4008, 1'b0, 1'b0);
    add_entry(32'h8000_4010, 1'b0, 1'b1);
    add_entry(32'h8000_401c, 1'b0, 1'b1);
    add_entry(32'h8000_4020, 1'b0, 1'b0);
    add_entry(32'h8000_1230, 1'b1, 1'b0);
    add_entry(32'h8000_1234, 1'b0, 1'b0);
    // jump straight onto the bad line
    add_entry(32'h8000_4010, 1'b1, 1'b1);
    add_entry(32'h8000_4014, 1'b0, 1'b1);
    add_entry(32'h8000_4024, 1'b0, 1'b0);
  endtask

  task automatic run_entry(input int idx);
    entry_t e;
    e = table_q[idx];
    @(posedge clk);
    pc_i        <= e.pc;
    jmp_flush_i <= e.flush;
    if (e.flush) begin
      seq_check   = 1'b0;
      resync_addr = {e.pc[31:4], 4'b0000};
      @(posedge clk);
      jmp_flush_i <= 1'b0;
    end
    @(negedge clk);
    while (!inst_valid_o) begin
      @(negedge clk);
    end
    if (idx == 0) begin
      // cold start, queue still empty, line comes through the bypass
      assert (r_valid_i && r_ready_o)
        else report_failure("first fetch was not served during the data transfer");
    end
    assert (inst_o == ~e.pc)
      else report_failure($sformatf("pc %h gave inst %h, expected %h", e.pc, inst_o, ~e.pc));
    assert (inst_err_o == e.err)
      else report_failure($sformatf("pc %h gave err %b, expected %b", e.pc, inst_err_o, e.err));
  endtask

  // pc parked on one line, reads must stop at DEPTH lines
  task automatic check_queue_full();
    repeat (60) @(negedge clk);
    assert (read_count == DEPTH)
      else report_failure($sformatf("%0d reads with a full queue", read_count));
    repeat (20) begin
      @(negedge clk);
      assert (!ar_valid_o)
        else report_failure("address request while the queue is full");
    end
  endtask

  // prefetch addresses climb by one line, resync after a jump
  always @(negedge clk) begin
    if (!rst_n && ar_valid_o && ar_ready_i) begin
      if (seq_check) begin
        assert (ar_addr_o == exp_addr)
          else report_failure($sformatf("read addr %h, expected %h", ar_addr_o, exp_addr));
        exp_addr = ar_addr_o + 32'd16;
      end else if (ar_addr_o == resync_addr) begin
        seq_check = 1'b1;
        exp_addr  = ar_addr_o + 32'd16;
      end
    end
  end

  // ========================================
  // main sequence and watchdog
  // ========================================

  initial begin
    rst_n       = 1'b1;
    pc_i        = RESET_PC;
    jmp_flush_i = 1'b0;
    seq_check   = 1'b1;
    exp_addr    = RESET_PC;
    resync_addr = RESET_PC;
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < TBL_SIZE; i++) begin
      run_entry(i);
      if (i == 0) begin
        check_queue_full();
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (TBL_SIZE * 40 + 5));
    $display("timeout: the fetch table did not complete within %0d cycles", TBL_SIZE * 40);
    $display("RESULT: FAIL");
    $fatal(1);
  end

endmodule

//--- all.f
design/fetch_pkg.sv
design/line_if.sv
design/bus_reader.sv
design/line_queue.sv
design/pc_tracker.sv
design/fetch_buffer.sv
verification/mem_model.sv
verification/fetch_buffer_asserts.sv
verification/tb_fetch_buffer.sv

//--- Bender.yml
package:
  name: fetch_buffer

sources:
  - files:
      - design/fetch_pkg.sv
      - design/line_if.sv
      - design/bus_reader.sv
      - design/line_queue.sv
      - design/pc_tracker.sv
      - design/fetch_buffer.sv
  - target: simulation
    files:
      - verification/mem_model.sv
      - verification/fetch_buffer_asserts.sv
      - verification/tb_fetch_buffer.sv
